/* common/cpu_consts.svh */
// Widths, major opcodes and ALU function codes of the ISA
// Fixed register numbers and the nop encoding
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath, address and register index widths
`define CPU_XLEN     32
`define CPU_REG_BITS 5

// Major opcodes in bits 31:27
`define CPU_OP_ALU  5'd0
`define CPU_OP_J    5'd1
`define CPU_OP_BNE  5'd2
`define CPU_OP_JAL  5'd3
`define CPU_OP_JR   5'd4
`define CPU_OP_ADDI 5'd5
`define CPU_OP_BLT  5'd6
`define CPU_OP_SW   5'd7
`define CPU_OP_LW   5'd8

// R-type function codes
`define CPU_ALU_ADD 5'd0
`define CPU_ALU_SUB 5'd1
`define CPU_ALU_AND 5'd2
`define CPU_ALU_OR  5'd3
`define CPU_ALU_SLL 5'd4
`define CPU_ALU_SRA 5'd5

// Return address register of jal
`define CPU_LINK_REG 5'd31

// Encodes add r0, r0, r0
`define CPU_NOP 32'h0000_0000

`endif

/* common/isa_pkg.sv */
// Instruction word type with its R, I and J field views
`default_nettype none
`include "cpu_consts.svh"

package isa_pkg;

    typedef struct packed {
        logic [4:0]               opcode;
        logic [`CPU_REG_BITS-1:0] rd;
        logic [`CPU_REG_BITS-1:0] rs;
        logic [`CPU_REG_BITS-1:0] rt;
        logic [4:0]               shamt;
        logic [4:0]               alu_op;
        logic [1:0]               pad;
    } insn_r_t;

    typedef struct packed {
        logic [4:0]               opcode;
        logic [`CPU_REG_BITS-1:0] rd;
        logic [`CPU_REG_BITS-1:0] rs;
        logic [16:0]              imm;
    } insn_i_t;

    typedef struct packed {
        logic [4:0]  opcode;
        logic [26:0] target;
    } insn_j_t;

    // One word, decoded by field layout of its format
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
        insn_j_t j;
    } insn_t;

endpackage

`default_nettype wire

/* decode/decode_stage.sv */
// Register read addressing, load-use detection
// and the decode/execute pipeline register
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module decode_stage (
    input  logic                      clock,
    input  logic                      rst_n,
    input  isa_pkg::insn_t            fd_insn,
    input  logic [`CPU_XLEN-1:0]      fd_pc_next,
    input  logic                      redirect,
    output logic [`CPU_REG_BITS-1:0]  read_reg_a,
    output logic [`CPU_REG_BITS-1:0]  read_reg_b,
    input  logic [`CPU_XLEN-1:0]      read_data_a,
    input  logic [`CPU_XLEN-1:0]      read_data_b,
    output logic                      load_stall,
    output isa_pkg::insn_t            dx_insn,
    output logic [`CPU_XLEN-1:0]      dx_pc_next,
    output logic [`CPU_XLEN-1:0]      dx_a,
    output logic [`CPU_XLEN-1:0]      dx_b
);

    logic [4:0] fd_op;
    logic [4:0] dx_op;
    logic       b_is_rd;
    logic       uses_a;
    logic       uses_b;
    logic       hit_a;
    logic       hit_b;

    assign fd_op = fd_insn.r.opcode;
    assign dx_op = dx_insn.i.opcode;

    // Stores, branches and jr take rd on port B
    assign b_is_rd = (fd_op == `CPU_OP_SW) || (fd_op == `CPU_OP_BNE) ||
                     (fd_op == `CPU_OP_BLT) || (fd_op == `CPU_OP_JR);

    assign read_reg_a = fd_insn.i.rs;
    assign read_reg_b = b_is_rd ? fd_insn.r.rd : fd_insn.r.rt;

    // Ports consumed in execute
    // sw store data is left out, it is bypassed in the memory stage
    assign uses_a = (fd_op == `CPU_OP_ALU) || (fd_op == `CPU_OP_ADDI) ||
                    (fd_op == `CPU_OP_LW) || (fd_op == `CPU_OP_SW) ||
                    (fd_op == `CPU_OP_BNE) || (fd_op == `CPU_OP_BLT);
    assign uses_b = (fd_op == `CPU_OP_ALU) || (fd_op == `CPU_OP_BNE) ||
                    (fd_op == `CPU_OP_BLT) || (fd_op == `CPU_OP_JR);

    assign hit_a = uses_a && (read_reg_a == dx_insn.i.rd);
    assign hit_b = uses_b && (read_reg_b == dx_insn.i.rd);

    assign load_stall = (dx_op == `CPU_OP_LW) && (dx_insn.i.rd != '0) && (hit_a || hit_b);

    // Bubble on a load-use hold, squash on a redirect
    always_ff @(posedge clock) begin
        if (!rst_n || redirect || load_stall)
            dx_insn <= `CPU_NOP;
        else
            dx_insn <= fd_insn;
    end

    always_ff @(posedge clock) begin
        dx_pc_next <= fd_pc_next;
        dx_a       <= read_data_a;
        dx_b       <= read_data_b;
    end

endmodule

`default_nettype wire

/* execute/alu.sv */
// Integer ALU with add, sub, and, or and both shifts
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module alu (
    input  logic [`CPU_XLEN-1:0] operand_a,
    input  logic [`CPU_XLEN-1:0] operand_b,
    input  logic [4:0]           alu_op,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 not_equal,
    output logic                 less_than
);

    always_comb begin
        case (alu_op)
            `CPU_ALU_ADD: result = operand_a + operand_b;
            `CPU_ALU_SUB: result = operand_a - operand_b;
            `CPU_ALU_AND: result = operand_a & operand_b;
            `CPU_ALU_OR:  result = operand_a | operand_b;
            `CPU_ALU_SLL: result = operand_a << shamt;
            // Sign bit fills from the left
            `CPU_ALU_SRA: result = $signed(operand_a) >>> shamt;
            default:      result = '0;
        endcase
    end

    // Branch flags
    assign not_equal = (operand_a != operand_b);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
// Operand bypassing, immediate selection and branch resolution
// plus the execute/memory pipeline register
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module execute_stage (
    input  logic                     clock,
    input  logic                     rst_n,
    input  isa_pkg::insn_t           dx_insn,
    input  logic [`CPU_XLEN-1:0]     dx_pc_next,
    input  logic [`CPU_XLEN-1:0]     dx_a,
    input  logic [`CPU_XLEN-1:0]     dx_b,
    input  logic                     wb_en,
    input  logic [`CPU_REG_BITS-1:0] wb_reg,
    input  logic [`CPU_XLEN-1:0]     wb_data,
    output logic                     redirect,
    output logic [`CPU_XLEN-1:0]     redirect_pc,
    output isa_pkg::insn_t           xm_insn,
    output logic [`CPU_XLEN-1:0]     xm_result,
    output logic [`CPU_XLEN-1:0]     xm_store_data
);

    logic [4:0]               op;
    logic [4:0]               xm_op;
    logic [`CPU_REG_BITS-1:0] src_a;
    logic [`CPU_REG_BITS-1:0] src_b;
    logic [`CPU_REG_BITS-1:0] xm_dest;
    logic                     xm_fwd;
    logic [`CPU_XLEN-1:0]     opnd_a;
    logic [`CPU_XLEN-1:0]     opnd_b;
    logic [`CPU_XLEN-1:0]     imm_ext;
    logic [`CPU_XLEN-1:0]     jump_target;
    logic                     use_imm;
    logic                     is_branch;
    logic [4:0]               alu_op;
    logic [`CPU_XLEN-1:0]     alu_b;
    logic [`CPU_XLEN-1:0]     alu_result;
    logic                     not_equal;
    logic                     less_than;
    logic [`CPU_XLEN-1:0]     ex_result;

    assign op    = dx_insn.r.opcode;
    assign xm_op = xm_insn.r.opcode;

    // Same port B choice as decode
    assign src_a = dx_insn.i.rs;
    assign src_b = (op == `CPU_OP_SW || op == `CPU_OP_BNE || op == `CPU_OP_BLT ||
                    op == `CPU_OP_JR) ? dx_insn.r.rd : dx_insn.r.rt;

    // A load in memory has only its address here, so it never bypasses
    assign xm_dest = (xm_op == `CPU_OP_JAL) ? `CPU_LINK_REG : xm_insn.i.rd;
    assign xm_fwd  = ((xm_op == `CPU_OP_ALU) || (xm_op == `CPU_OP_ADDI) ||
                      (xm_op == `CPU_OP_JAL)) && (xm_dest != '0);

    // Youngest producer first
    assign opnd_a = (xm_fwd && xm_dest == src_a) ? xm_result :
                    (wb_en && wb_reg == src_a)   ? wb_data   : dx_a;
    assign opnd_b = (xm_fwd && xm_dest == src_b) ? xm_result :
                    (wb_en && wb_reg == src_b)   ? wb_data   : dx_b;

    assign imm_ext     = {{15{dx_insn.i.imm[16]}}, dx_insn.i.imm};
    assign jump_target = {{5{dx_insn.j.target[26]}}, dx_insn.j.target};

    assign use_imm   = (op == `CPU_OP_ADDI) || (op == `CPU_OP_LW) || (op == `CPU_OP_SW);
    assign is_branch = (op == `CPU_OP_BNE) || (op == `CPU_OP_BLT);

    // Address and immediate math add, compares subtract
    assign alu_op = use_imm   ? `CPU_ALU_ADD :
                    is_branch ? `CPU_ALU_SUB : dx_insn.r.alu_op;
    assign alu_b  = use_imm ? imm_ext : opnd_b;

    alu alu_i (
        .operand_a (opnd_a),
        .operand_b (alu_b),
        .alu_op    (alu_op),
        .shamt     (dx_insn.r.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Operand A is rs and B is rd, so blt wants B < A
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = dx_pc_next + imm_ext;
        case (op)
            `CPU_OP_BNE: redirect = not_equal;
            `CPU_OP_BLT: redirect = not_equal && !less_than;
            `CPU_OP_J, `CPU_OP_JAL: begin
                redirect    = 1'b1;
                redirect_pc = jump_target;
            end
            `CPU_OP_JR: begin
                redirect    = 1'b1;
                redirect_pc = opnd_b;
            end
            default: redirect = 1'b0;
        endcase
    end

    // jal links to the address after itself
    assign ex_result = (op == `CPU_OP_JAL) ? dx_pc_next : alu_result;

    always_ff @(posedge clock) begin
        if (!rst_n)
            xm_insn <= `CPU_NOP;
        else
            xm_insn <= dx_insn;
    end

    always_ff @(posedge clock) begin
        xm_result     <= ex_result;
        xm_store_data <= opnd_b;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the CPU testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_tb -f tb.f -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log

/* src/cpu_top.sv */
// Five-stage pipelined CPU top level
// Connects the stages, the register file and the memory ports
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_top (
    input  logic                 clock,
    input  logic                 rst_n,
    output logic [`CPU_XLEN-1:0] address_imem,
    input  logic [`CPU_XLEN-1:0] q_imem,
    output logic [`CPU_XLEN-1:0] address_dmem,
    output logic [`CPU_XLEN-1:0] data,
    output logic                 wren,
    input  logic [`CPU_XLEN-1:0] q_dmem
);

    import isa_pkg::*;

    // Fetch to decode
    insn_t                    fd_insn;
    logic [`CPU_XLEN-1:0]     fd_pc_next;
    logic                     load_stall;

    // Register file read side
    logic [`CPU_REG_BITS-1:0] read_reg_a;
    logic [`CPU_REG_BITS-1:0] read_reg_b;
    logic [`CPU_XLEN-1:0]     read_data_a;
    logic [`CPU_XLEN-1:0]     read_data_b;

    // Decode to execute
    insn_t                    dx_insn;
    logic [`CPU_XLEN-1:0]     dx_pc_next;
    logic [`CPU_XLEN-1:0]     dx_a;
    logic [`CPU_XLEN-1:0]     dx_b;

    // Control transfer back to the front end
    logic                     redirect;
    logic [`CPU_XLEN-1:0]     redirect_pc;

    // Execute to memory
    insn_t                    xm_insn;
    logic [`CPU_XLEN-1:0]     xm_result;
    logic [`CPU_XLEN-1:0]     xm_store_data;

    // Writeback port, also the late bypass source
    logic                     wb_en;
    logic [`CPU_REG_BITS-1:0] wb_reg;
    logic [`CPU_XLEN-1:0]     wb_data;

    fetch_stage fetch_stage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .load_stall   (load_stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd_insn      (fd_insn),
        .fd_pc_next   (fd_pc_next)
    );

    decode_stage decode_stage_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .fd_insn     (fd_insn),
        .fd_pc_next  (fd_pc_next),
        .redirect    (redirect),
        .read_reg_a  (read_reg_a),
        .read_reg_b  (read_reg_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .load_stall  (load_stall),
        .dx_insn     (dx_insn),
        .dx_pc_next  (dx_pc_next),
        .dx_a        (dx_a),
        .dx_b        (dx_b)
    );

    execute_stage execute_stage_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .dx_insn       (dx_insn),
        .dx_pc_next    (dx_pc_next),
        .dx_a          (dx_a),
        .dx_b          (dx_b),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .xm_insn       (xm_insn),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data)
    );

    result_stage result_stage_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .xm_insn       (xm_insn),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data),
        .q_dmem        (q_dmem),
        .address_dmem  (address_dmem),
        .data          (data),
        .wren          (wren),
        .wb_en         (wb_en),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data)
    );

    reg_file reg_file_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .read_reg_a  (read_reg_a),
        .read_reg_b  (read_reg_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// Program counter, next-PC selection and fetch/decode register
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 load_stall,
    input  logic                 redirect,
    input  logic [`CPU_XLEN-1:0] redirect_pc,
    input  logic [`CPU_XLEN-1:0] q_imem,
    output logic [`CPU_XLEN-1:0] address_imem,
    output isa_pkg::insn_t       fd_insn,
    output logic [`CPU_XLEN-1:0] fd_pc_next
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_plus_one;
    logic [`CPU_XLEN-1:0] pc_next;

    assign address_imem = pc;
    assign pc_plus_one  = pc + 32'd1;

    // A taken transfer wins over a load-use hold
    always_comb begin
        if (redirect)
            pc_next = redirect_pc;
        else if (load_stall)
            pc_next = pc;
        else
            pc_next = pc_plus_one;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc      <= '0;
            fd_insn <= `CPU_NOP;
        end else begin
            pc <= pc_next;
            // Word fetched under a redirect is the younger squashed slot
            if (redirect)
                fd_insn <= `CPU_NOP;
            else if (!load_stall)
                fd_insn <= q_imem;
        end
    end

    // Address following the fetched word
    always_ff @(posedge clock) begin
        if (!load_stall)
            fd_pc_next <= pc_plus_one;
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
// 32-entry register file with r0 tied to zero
// and write-through on both read ports
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic [`CPU_REG_BITS-1:0] read_reg_a,
    input  logic [`CPU_REG_BITS-1:0] read_reg_b,
    output logic [`CPU_XLEN-1:0]     read_data_a,
    output logic [`CPU_XLEN-1:0]     read_data_b,
    input  logic                     wb_en,
    input  logic [`CPU_REG_BITS-1:0] wb_reg,
    input  logic [`CPU_XLEN-1:0]     wb_data
);

    logic [`CPU_XLEN-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wb_en && wb_reg != '0)
            regs[wb_reg] <= wb_data;
    end

    // Decode sees a result retiring in the same cycle
    assign read_data_a = (read_reg_a == '0)                 ? '0      :
                         (wb_en && wb_reg == read_reg_a)    ? wb_data : regs[read_reg_a];
    assign read_data_b = (read_reg_b == '0)                 ? '0      :
                         (wb_en && wb_reg == read_reg_b)    ? wb_data : regs[read_reg_b];

endmodule

`default_nettype wire

/* src/result_stage.sv */
// Data memory access with store data bypass
// and the memory/writeback register with result selection
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module result_stage (
    input  logic                     clock,
    input  logic                     rst_n,
    input  isa_pkg::insn_t           xm_insn,
    input  logic [`CPU_XLEN-1:0]     xm_result,
    input  logic [`CPU_XLEN-1:0]     xm_store_data,
    input  logic [`CPU_XLEN-1:0]     q_dmem,
    output logic [`CPU_XLEN-1:0]     address_dmem,
    output logic [`CPU_XLEN-1:0]     data,
    output logic                     wren,
    output logic                     wb_en,
    output logic [`CPU_REG_BITS-1:0] wb_reg,
    output logic [`CPU_XLEN-1:0]     wb_data
);

    import isa_pkg::*;

    insn_t                mw_insn;
    logic [`CPU_XLEN-1:0] mw_result;
    logic [`CPU_XLEN-1:0] mw_load;
    logic [4:0]           wb_op;
    logic                 wb_writes;

    assign address_dmem = xm_result;
    assign wren         = (xm_insn.r.opcode == `CPU_OP_SW);

    // A load or ALU result one stage ahead replaces stale store data
    assign data = (wb_en && wb_reg == xm_insn.i.rd) ? wb_data : xm_store_data;

    always_ff @(posedge clock) begin
        if (!rst_n)
            mw_insn <= `CPU_NOP;
        else
            mw_insn <= xm_insn;
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;
    end

    assign wb_op     = mw_insn.r.opcode;
    assign wb_writes = (wb_op == `CPU_OP_ALU) || (wb_op == `CPU_OP_ADDI) ||
                       (wb_op == `CPU_OP_LW) || (wb_op == `CPU_OP_JAL);
    assign wb_reg    = (wb_op == `CPU_OP_JAL) ? `CPU_LINK_REG : mw_insn.i.rd;

    // Writes to r0 never leave this stage, so no bypass matches r0
    assign wb_en   = wb_writes && (wb_reg != '0);
    assign wb_data = (wb_op == `CPU_OP_LW) ? mw_load : mw_result;

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
+incdir+verification
common/isa_pkg.sv
execute/alu.sv
execute/execute_stage.sv
decode/decode_stage.sv
src/fetch_stage.sv
src/result_stage.sv
src/reg_file.sv
src/cpu_top.sv
verification/cpu_tb.sv

/* verification/tb_programs.svh */
// Test programs, preset data words and expected store traces
// Instruction encoders used to build the programs
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

`define NUM_TESTS  5
`define MAX_STORES 8

string       test_name  [`NUM_TESTS];
logic [31:0] prog       [`NUM_TESTS][16];
logic [31:0] preset_addr[`NUM_TESTS];
logic [31:0] preset_word[`NUM_TESTS];
int          exp_count  [`NUM_TESTS];
logic [31:0] exp_addr   [`NUM_TESTS][`MAX_STORES];
logic [31:0] exp_data   [`NUM_TESTS][`MAX_STORES];

function automatic logic [31:0] alu_word(input logic [4:0] fn, input int rd, input int rs,
                                         input int rt, input int shamt);
    return {`CPU_OP_ALU, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], fn, 2'b00};
endfunction

function automatic logic [31:0] imm_word(input logic [4:0] op, input int rd, input int rs,
                                         input int imm);
    return {op, rd[4:0], rs[4:0], imm[16:0]};
endfunction

function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
    return {op, target[26:0]};
endfunction

function automatic logic [31:0] sext17(input int imm);
    logic [16:0] v;
    v = imm[16:0];
    return {{15{v[16]}}, v};
endfunction

// Stores one expected (address, data) pair
task automatic expect_store(input int t, input logic [31:0] addr, input logic [31:0] value);
    exp_addr[t][exp_count[t]] = addr;
    exp_data[t][exp_count[t]] = value;
    exp_count[t]++;
endtask

task automatic build_tests(input logic [31:0] rnd);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] f;
    logic [31:0] g;
    logic [31:0] h;
    logic [31:0] k;
    for (int t = 0; t < `NUM_TESTS; t++) begin
        exp_count[t]   = 0;
        preset_addr[t] = 32'd8;
        preset_word[t] = 32'h0;
        for (int w = 0; w < 16; w++)
            prog[t][w] = `CPU_NOP;
    end

    // Each ALU op consumes the result just before it
    test_name[0] = "alu_chain";
    prog[0][0]  = imm_word(`CPU_OP_ADDI, 1, 0, 13);
    prog[0][1]  = imm_word(`CPU_OP_ADDI, 2, 0, 6);
    prog[0][2]  = alu_word(`CPU_ALU_ADD, 3, 1, 2, 0);
    prog[0][3]  = alu_word(`CPU_ALU_SUB, 4, 3, 2, 0);
    prog[0][4]  = alu_word(`CPU_ALU_AND, 5, 4, 3, 0);
    prog[0][5]  = alu_word(`CPU_ALU_OR,  6, 5, 4, 0);
    prog[0][6]  = alu_word(`CPU_ALU_SLL, 7, 6, 0, 4);
    prog[0][7]  = alu_word(`CPU_ALU_SUB, 8, 0, 7, 0);
    prog[0][8]  = alu_word(`CPU_ALU_SRA, 9, 8, 0, 2);
    prog[0][9]  = imm_word(`CPU_OP_SW, 3, 0, 0);
    prog[0][10] = imm_word(`CPU_OP_SW, 4, 0, 1);
    prog[0][11] = imm_word(`CPU_OP_SW, 5, 0, 2);
    prog[0][12] = imm_word(`CPU_OP_SW, 6, 0, 3);
    prog[0][13] = imm_word(`CPU_OP_SW, 7, 0, 4);
    prog[0][14] = imm_word(`CPU_OP_SW, 9, 0, 5);
    prog[0][15] = jump_word(`CPU_OP_J, 15);
    a = 32'd13;
    b = 32'd6;
    c = a + b;
    d = c - b;
    e = d & c;
    f = e | d;
    g = f << 4;
    h = 32'd0 - g;
    k = $signed(h) >>> 2;
    expect_store(0, 0, c);
    expect_store(0, 1, d);
    expect_store(0, 2, e);
    expect_store(0, 3, f);
    expect_store(0, 4, g);
    expect_store(0, 5, k);

    test_name[1] = "addi_neg_r0";
    prog[1][0] = imm_word(`CPU_OP_ADDI, 1, 0, -5);
    prog[1][1] = imm_word(`CPU_OP_ADDI, 2, 1, -1000);
    prog[1][2] = imm_word(`CPU_OP_ADDI, 0, 0, 77);
    prog[1][3] = imm_word(`CPU_OP_SW, 2, 0, 0);
    prog[1][4] = imm_word(`CPU_OP_SW, 0, 0, 1);
    prog[1][5] = imm_word(`CPU_OP_SW, 1, 0, 2);
    prog[1][6] = jump_word(`CPU_OP_J, 6);
    a = sext17(-5);
    expect_store(1, 0, a + sext17(-1000));
    expect_store(1, 1, 32'd0);
    expect_store(1, 2, a);

    // Load-use stall, then load feeding store data
    test_name[2] = "load_use";
    preset_word[2] = rnd;
    prog[2][0] = imm_word(`CPU_OP_ADDI, 1, 0, 8);
    prog[2][1] = imm_word(`CPU_OP_ADDI, 2, 0, 100);
    prog[2][2] = imm_word(`CPU_OP_LW, 3, 1, 0);
    prog[2][3] = alu_word(`CPU_ALU_ADD, 4, 3, 2, 0);
    prog[2][4] = imm_word(`CPU_OP_SW, 4, 0, 0);
    prog[2][5] = imm_word(`CPU_OP_LW, 5, 1, 0);
    prog[2][6] = imm_word(`CPU_OP_SW, 5, 0, 1);
    prog[2][7] = jump_word(`CPU_OP_J, 7);
    expect_store(2, 0, rnd + 32'd100);
    expect_store(2, 1, rnd);

    // Branch rd against rs, target is next address plus imm
    test_name[3] = "branches";
    prog[3][0]  = imm_word(`CPU_OP_ADDI, 1, 0, 5);
    prog[3][1]  = imm_word(`CPU_OP_ADDI, 2, 0, -3);
    prog[3][2]  = imm_word(`CPU_OP_BNE, 1, 1, 2);
    prog[3][3]  = imm_word(`CPU_OP_SW, 1, 0, 0);
    prog[3][4]  = imm_word(`CPU_OP_BNE, 1, 2, 2);
    prog[3][5]  = imm_word(`CPU_OP_SW, 1, 0, 1);
    prog[3][6]  = imm_word(`CPU_OP_SW, 1, 0, 2);
    prog[3][7]  = imm_word(`CPU_OP_BLT, 2, 1, 2);
    prog[3][8]  = imm_word(`CPU_OP_SW, 2, 0, 3);
    prog[3][9]  = imm_word(`CPU_OP_SW, 2, 0, 4);
    prog[3][10] = imm_word(`CPU_OP_BLT, 1, 2, 3);
    prog[3][11] = imm_word(`CPU_OP_SW, 2, 0, 5);
    prog[3][12] = jump_word(`CPU_OP_J, 12);
    expect_store(3, 0, 32'd5);
    expect_store(3, 5, sext17(-3));

    // Call, skip, return through r31
    test_name[4] = "jumps";
    prog[4][0] = jump_word(`CPU_OP_JAL, 3);
    prog[4][1] = imm_word(`CPU_OP_SW, 31, 0, 1);
    prog[4][2] = jump_word(`CPU_OP_J, 8);
    prog[4][3] = imm_word(`CPU_OP_SW, 31, 0, 0);
    prog[4][4] = jump_word(`CPU_OP_J, 6);
    prog[4][5] = imm_word(`CPU_OP_SW, 31, 0, 5);
    prog[4][6] = imm_word(`CPU_OP_JR, 31, 0, 0);
    prog[4][7] = imm_word(`CPU_OP_SW, 31, 0, 6);
    prog[4][8] = jump_word(`CPU_OP_J, 8);
    expect_store(4, 0, 32'd0 + 32'd1);
    expect_store(4, 1, 32'd0 + 32'd1);
endtask

`endif

/* verification/cpu_tb.sv */
// Testbench for the pipelined CPU
// Memory models, store trace capture and the table-driven test loop
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_tb;

    `include "tb_programs.svh"

    logic        clock;
    logic        rst_n;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;

    logic [31:0] imem [16];
    logic [31:0] dmem [64];

    logic [31:0] trace_addr[$];
    logic [31:0] trace_data[$];

    int pass_count;
    int fail_count;

    cpu_top cpu_top_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Both memories answer in the same cycle
    assign q_imem = (address_imem < 32'd16) ? imem[address_imem[3:0]] : `CPU_NOP;
    assign q_dmem = dmem[address_dmem[5:0]];

    // Store bus is stable at the falling edge
    always @(negedge clock) begin
        if (rst_n && wren) begin
            dmem[address_dmem[5:0]] = data;
            trace_addr.push_back(address_dmem);
            trace_data.push_back(data);
        end
    end

    task automatic load_memories(input int t);
        for (int w = 0; w < 16; w++)
            imem[w] = prog[t][w];
        for (int i = 0; i < 64; i++)
            dmem[i] = (i * 32'h0101_0101) ^ 32'hC3C3_0000;
        dmem[preset_addr[t][5:0]] = preset_word[t];
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        #1 rst_n = 1'b1;
    endtask

    task automatic run_one_test(input int t);
        int  cycles;
        bit  ok;
        ok = 1'b1;
        @(posedge clock);
        #1;
        load_memories(t);
        trace_addr.delete();
        trace_data.delete();
        apply_reset();

        cycles = 0;
        while (trace_addr.size() < exp_count[t] && cycles < 200) begin
            @(posedge clock);
            cycles++;
        end
        if (trace_addr.size() < exp_count[t]) begin
            $display("%s: timed out with %0d of %0d stores seen", test_name[t],
                     trace_addr.size(), exp_count[t]);
            ok = 1'b0;
        end else begin
            // Let the program settle in its final loop
            cycles = 0;
            while (cycles < 30) begin
                @(posedge clock);
                cycles++;
            end
            if (trace_addr.size() > exp_count[t]) begin
                $display("%s: %0d stores seen where %0d were expected", test_name[t],
                         trace_addr.size(), exp_count[t]);
                ok = 1'b0;
            end
            for (int i = 0; i < exp_count[t]; i++) begin
                if (trace_addr[i] !== exp_addr[t][i] || trace_data[i] !== exp_data[t][i]) begin
                    $display("Fail %s store %0d: expected addr %0d data %h, actual addr %0d data %h",
                             test_name[t], i, exp_addr[t][i], exp_data[t][i],
                             trace_addr[i], trace_data[i]);
                    ok = 1'b0;
                end
            end
        end

        if (ok) begin
            $display("Pass %s", test_name[t]);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        rst_n      = 1'b0;
        pass_count = 0;
        fail_count = 0;
        for (int w = 0; w < 16; w++)
            imem[w] = `CPU_NOP;
        for (int i = 0; i < 64; i++)
            dmem[i] = '0;

        rnd = $urandom(30064);
        rnd = $urandom;
        build_tests(rnd);

        for (int t = 0; t < `NUM_TESTS; t++)
            run_one_test(t);

        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
